// ==== hdl/tcdm_req_pkg.sv ====
package tcdm_req_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // Word address seen by the memory bank
    localparam int unsigned ADDR_WIDTH = 32;

    localparam int unsigned DATA_WIDTH = 32;

    localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

    // One-hot master ID, channel 0 in the low bits and channel 1 above
    localparam int unsigned ID_WIDTH   = 8;

    // Data word written by the automatic set store
    localparam logic [DATA_WIDTH-1:0] TS_SET_VALUE = '1;

    //////////////////////////////////////////////////////////////////////
    // Address word
    //////////////////////////////////////////////////////////////////////

    // Decoded view, test-and-set flag sits on top of the word address
    typedef struct packed {
        logic                  ts;
        logic [ADDR_WIDTH-1:0] addr;
    } req_addr_dec_t;

    // Arbiters only move the raw word, the test-and-set stage decodes it
    typedef union packed {
        logic [ADDR_WIDTH:0] raw;
        req_addr_dec_t       dec;
    } req_addr_t;

    //////////////////////////////////////////////////////////////////////
    // Request payloads
    //////////////////////////////////////////////////////////////////////

    // Master side request, wen high means load
    typedef struct packed {
        req_addr_t             addr;
        logic                  wen;
        logic [DATA_WIDTH-1:0] wdata;
        logic [BE_WIDTH-1:0]   be;
        logic [ID_WIDTH-1:0]   id;
    } tcdm_req_t;

    // Memory side request
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic                  wen;
        logic [DATA_WIDTH-1:0] wdata;
        logic [BE_WIDTH-1:0]   be;
        logic [ID_WIDTH-1:0]   id;
        // High only for the store half of a test-and-set
        logic                  ts_set;
    } mem_req_t;

endpackage

// ==== hdl/rr_arbiter.sv ====
module rr_arbiter #(
    parameter int unsigned N_MASTER = 4
) (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,

    // Masters of one channel
    input  logic [N_MASTER-1:0]                    req_i,
    input  tcdm_req_pkg::tcdm_req_t [N_MASTER-1:0] payload_i,
    output logic [N_MASTER-1:0]                    gnt_o,

    // Channel winner towards the channel mux
    output logic                                   req_o,
    output tcdm_req_pkg::tcdm_req_t                payload_o,
    input  logic                                   gnt_i
);

    localparam int unsigned PTR_W = (N_MASTER > 1) ? $clog2(N_MASTER) : 1;
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(N_MASTER - 1);

    // Round-robin pointer, index with the highest priority
    logic [PTR_W-1:0] ptr_q;
    logic [PTR_W-1:0] win_idx;
    logic             xfer;

    //////////////////////////////////////////////////////////////////////
    // Winner selection
    //////////////////////////////////////////////////////////////////////

    // Walk the ring backwards so the closest requester to the pointer
    // is the last one written
    always_comb
    begin : sel_winner
        int unsigned cand;

        win_idx = ptr_q;
        for (int i = N_MASTER - 1; i >= 0; i--)
        begin
            cand = int'(ptr_q) + i;
            if (cand >= N_MASTER)
            begin
                cand = cand - N_MASTER;
            end
            if (req_i[cand])
            begin
                win_idx = PTR_W'(cand);
            end
        end
    end

    assign req_o     = |req_i;
    assign payload_o = payload_i[win_idx];
    assign xfer      = req_o & gnt_i;

    // Grant goes back only to the winner
    always_comb
    begin
        gnt_o          = '0;
        gnt_o[win_idx] = xfer;
    end

    //////////////////////////////////////////////////////////////////////
    // Pointer update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            ptr_q <= '0;
        end
        else if (xfer)
        begin
            // Pointer moves just past the winner, wrapping at the end
            if (win_idx == LAST_IDX)
            begin
                ptr_q <= '0;
            end
            else
            begin
                ptr_q <= win_idx + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // At most one master sees a grant per cycle
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(gnt_o));

    // No grant to a master that is not requesting
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (gnt_o & ~req_i) == '0);

endmodule

// ==== hdl/channel_mux.sv ====
module channel_mux (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    // Channel 0 winner, cores
    input  logic                    ch0_req_i,
    input  tcdm_req_pkg::tcdm_req_t ch0_payload_i,
    output logic                    ch0_gnt_o,

    // Channel 1 winner, DMA engines
    input  logic                    ch1_req_i,
    input  tcdm_req_pkg::tcdm_req_t ch1_payload_i,
    output logic                    ch1_gnt_o,

    // Towards the test-and-set stage
    output logic                    req_o,
    output tcdm_req_pkg::tcdm_req_t payload_o,
    input  logic                    gnt_i
);

    // Priority flag, low gives channel 0 precedence
    logic prio_ch1_q;
    logic sel_ch1;
    logic both_req;

    assign both_req = ch0_req_i & ch1_req_i;

    // A lone requester always wins, on contention the flag decides
    assign sel_ch1 = ch1_req_i & (~ch0_req_i | prio_ch1_q);

    assign req_o     = ch0_req_i | ch1_req_i;
    assign payload_o = sel_ch1 ? ch1_payload_i : ch0_payload_i;

    assign ch0_gnt_o = gnt_i & ch0_req_i & ~sel_ch1;
    assign ch1_gnt_o = gnt_i & sel_ch1;

    //////////////////////////////////////////////////////////////////////
    // Flag update
    //////////////////////////////////////////////////////////////////////

    // Flag only toggles on a granted transfer under contention
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            prio_ch1_q <= 1'b0;
        end
        else if (both_req && gnt_i)
        begin
            prio_ch1_q <= ~prio_ch1_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Both channels are never granted in the same cycle
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ch0_gnt_o && ch1_gnt_o));

    // Under steady contention the winning channel alternates
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (both_req && ch0_gnt_o) ##1 (both_req && gnt_i) |-> ch1_gnt_o);

endmodule

// ==== hdl/test_and_set.sv ====
module test_and_set (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    // From the channel mux
    input  logic                    req_i,
    input  tcdm_req_pkg::tcdm_req_t payload_i,
    output logic                    gnt_o,

    // Memory port
    output logic                    mem_req_o,
    output tcdm_req_pkg::mem_req_t  mem_payload_o,
    input  logic                    mem_gnt_i
);

    import tcdm_req_pkg::*;

    // Set store waiting for its memory grant
    logic                  pending_q;
    logic [ADDR_WIDTH-1:0] ts_addr_q;
    logic [ID_WIDTH-1:0]   ts_id_q;

    logic                  ts_load;
    logic                  arm;

    // Flagged load, wen high means load
    assign ts_load = payload_i.addr.dec.ts & payload_i.wen;

    // Upstream is stalled while the set store occupies the port
    assign gnt_o = req_i & mem_gnt_i & ~pending_q;
    assign arm   = gnt_o & ts_load;

    //////////////////////////////////////////////////////////////////////
    // Memory port drive
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        if (pending_q)
        begin
            mem_req_o            = 1'b1;
            mem_payload_o.addr   = ts_addr_q;
            mem_payload_o.wen    = 1'b0;
            mem_payload_o.wdata  = TS_SET_VALUE;
            mem_payload_o.be     = '1;
            mem_payload_o.id     = ts_id_q;
            mem_payload_o.ts_set = 1'b1;
        end
        else
        begin
            // Normal pass-through, the flag bit is stripped from the address
            mem_req_o            = req_i;
            mem_payload_o.addr   = payload_i.addr.dec.addr;
            mem_payload_o.wen    = payload_i.wen;
            mem_payload_o.wdata  = payload_i.wdata;
            mem_payload_o.be     = payload_i.be;
            mem_payload_o.id     = payload_i.id;
            mem_payload_o.ts_set = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Set store sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            pending_q <= 1'b0;
        end
        else if (pending_q)
        begin
            // Leave once memory accepts the set store
            pending_q <= ~mem_gnt_i;
        end
        else
        begin
            pending_q <= arm;
        end
    end

    // Address and ID of the load are replayed by the set store
    always_ff @(posedge clk_i)
    begin
        if (arm)
        begin
            ts_addr_q <= payload_i.addr.dec.addr;
            ts_id_q   <= payload_i.id;
        end
    end

    // A granted flagged load is followed by a set store on the same word
    // with the upstream grant held low
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        arm |=> (mem_req_o && mem_payload_o.ts_set && !gnt_o
                 && mem_payload_o.addr == $past(payload_i.addr.dec.addr)
                 && mem_payload_o.id == $past(payload_i.id)));

endmodule

// ==== hdl/tcdm_request_block.sv ====
module tcdm_request_block #(
    parameter int unsigned N_CH0 = 4,
    parameter int unsigned N_CH1 = 2
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    // Channel 0, cores
    input  logic [N_CH0-1:0]                    ch0_req_i,
    input  tcdm_req_pkg::tcdm_req_t [N_CH0-1:0] ch0_payload_i,
    output logic [N_CH0-1:0]                    ch0_gnt_o,

    // Channel 1, DMA engines
    input  logic [N_CH1-1:0]                    ch1_req_i,
    input  tcdm_req_pkg::tcdm_req_t [N_CH1-1:0] ch1_payload_i,
    output logic [N_CH1-1:0]                    ch1_gnt_o,

    // Memory port
    output logic                                mem_req_o,
    output tcdm_req_pkg::mem_req_t              mem_payload_o,
    input  logic                                mem_gnt_i,

    // Response valid routing
    input  logic                                r_valid_i,
    input  logic [tcdm_req_pkg::ID_WIDTH-1:0]   r_id_i,
    output logic [N_CH0-1:0]                    ch0_r_valid_o,
    output logic [N_CH1-1:0]                    ch1_r_valid_o
);

    import tcdm_req_pkg::*;

    // Channel winners
    logic      ch0_win_req;
    tcdm_req_t ch0_win_payload;
    logic      ch0_win_gnt;

    logic      ch1_win_req;
    tcdm_req_t ch1_win_payload;
    logic      ch1_win_gnt;

    // Channel mux to test-and-set
    logic      mux_req;
    tcdm_req_t mux_payload;
    logic      mux_gnt;

    //////////////////////////////////////////////////////////////////////
    // Request path
    //////////////////////////////////////////////////////////////////////

    rr_arbiter #(
        .N_MASTER ( N_CH0 )
    ) i_ch0_arb (
        .clk_i     ( clk_i           ),
        .rst_n_i   ( rst_n_i         ),
        .req_i     ( ch0_req_i       ),
        .payload_i ( ch0_payload_i   ),
        .gnt_o     ( ch0_gnt_o       ),
        .req_o     ( ch0_win_req     ),
        .payload_o ( ch0_win_payload ),
        .gnt_i     ( ch0_win_gnt     )
    );

    rr_arbiter #(
        .N_MASTER ( N_CH1 )
    ) i_ch1_arb (
        .clk_i     ( clk_i           ),
        .rst_n_i   ( rst_n_i         ),
        .req_i     ( ch1_req_i       ),
        .payload_i ( ch1_payload_i   ),
        .gnt_o     ( ch1_gnt_o       ),
        .req_o     ( ch1_win_req     ),
        .payload_o ( ch1_win_payload ),
        .gnt_i     ( ch1_win_gnt     )
    );

    channel_mux i_channel_mux (
        .clk_i         ( clk_i           ),
        .rst_n_i       ( rst_n_i         ),
        .ch0_req_i     ( ch0_win_req     ),
        .ch0_payload_i ( ch0_win_payload ),
        .ch0_gnt_o     ( ch0_win_gnt     ),
        .ch1_req_i     ( ch1_win_req     ),
        .ch1_payload_i ( ch1_win_payload ),
        .ch1_gnt_o     ( ch1_win_gnt     ),
        .req_o         ( mux_req         ),
        .payload_o     ( mux_payload     ),
        .gnt_i         ( mux_gnt         )
    );

    test_and_set i_test_and_set (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .req_i         ( mux_req       ),
        .payload_i     ( mux_payload   ),
        .gnt_o         ( mux_gnt       ),
        .mem_req_o     ( mem_req_o     ),
        .mem_payload_o ( mem_payload_o ),
        .mem_gnt_i     ( mem_gnt_i     )
    );

    //////////////////////////////////////////////////////////////////////
    // Response valid decode
    //////////////////////////////////////////////////////////////////////

    // Channel 1 IDs start right above the channel 0 bits
    assign ch0_r_valid_o = {N_CH0{r_valid_i}} & r_id_i[N_CH0-1:0];
    assign ch1_r_valid_o = {N_CH1{r_valid_i}} & r_id_i[N_CH0 +: N_CH1];

    // Every accepted master request reaches exactly one master grant
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mem_req_o && mem_gnt_i && !mem_payload_o.ts_set)
            |-> $onehot({ch1_gnt_o, ch0_gnt_o}));

endmodule

// ==== test/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// State the request block holds between cycles
typedef struct packed {
    logic [7:0]            ptr0;
    logic [7:0]            ptr1;
    logic                  prio_ch1;
    logic                  pending;
    logic [ADDR_WIDTH-1:0] ts_addr;
    logic [ID_WIDTH-1:0]   ts_id;
} ref_state_t;

typedef struct packed {
    logic        mem_req;
    mem_req_t    mem;
    master_vec_t gnt;
} ref_out_t;

// First requester at or after the pointer, -1 for an idle channel
function automatic int rr_pick(master_vec_t rq, int base, int cnt, int ptr);
    int idx;
    for (int i = 0; i < cnt; i++)
    begin
        idx = (ptr + i) % cnt;
        if (rq[base + idx])
        begin
            return idx;
        end
    end
    return -1;
endfunction

function automatic void ref_step(input ref_state_t s, input master_vec_t rq,
                                 input tcdm_req_t [N_ALL-1:0] py, input logic mem_gnt_in,
                                 output ref_out_t o, output ref_state_t n);
    int        w0;
    int        w1;
    logic      use_ch1;
    tcdm_req_t p;

    o = '0;
    n = s;
    if (s.pending)
    begin
        // Set store owns the port, nothing upstream moves
        o.mem_req = 1'b1;
        o.mem     = '{addr: s.ts_addr, wen: 1'b0, wdata: TS_SET_VALUE, be: '1,
                      id: s.ts_id, ts_set: 1'b1};
        n.pending = !mem_gnt_in;
        return;
    end
    w0 = rr_pick(rq, 0, N_CH0, int'(s.ptr0));
    w1 = rr_pick(rq, N_CH0, N_CH1, int'(s.ptr1));
    if (w0 < 0 && w1 < 0)
    begin
        return;
    end
    use_ch1 = (w1 >= 0) && (w0 < 0 || s.prio_ch1);
    if (use_ch1)
    begin
        p = py[N_CH0 + w1];
    end
    else
    begin
        p = py[w0];
    end
    o.mem_req = 1'b1;
    o.mem     = '{addr: p.addr.dec.addr, wen: p.wen, wdata: p.wdata, be: p.be,
                  id: p.id, ts_set: 1'b0};
    if (mem_gnt_in)
    begin
        if (use_ch1)
        begin
            o.gnt[N_CH0 + w1] = 1'b1;
            n.ptr1 = 8'((w1 + 1) % N_CH1);
        end
        else
        begin
            o.gnt[w0] = 1'b1;
            n.ptr0 = 8'((w0 + 1) % N_CH0);
        end
        // Contention hands priority to the other channel
        if (w0 >= 0 && w1 >= 0)
        begin
            n.prio_ch1 = !s.prio_ch1;
        end
        if (p.addr.dec.ts && p.wen)
        begin
            n.pending = 1'b1;
            n.ts_addr = p.addr.dec.addr;
            n.ts_id   = p.id;
        end
    end
endfunction

// Channel 1 masters own the ID bits right above channel 0
function automatic master_vec_t expected_rvalid(logic valid, logic [ID_WIDTH-1:0] id);
    return valid ? id[N_ALL-1:0] : '0;
endfunction

task automatic check_mem_port(string name, logic exp_req, mem_req_t exp,
                              logic act_req, mem_req_t act);
    if (act_req !== exp_req || (exp_req && act !== exp))
    begin
        $display("ERR %s mem port expected req=%b %h actual req=%b %h",
                 name, exp_req, exp, act_req, act);
        abort_run();
    end
endtask

task automatic check_grants(string name, master_vec_t exp, master_vec_t act);
    if (act !== exp)
    begin
        $display("ERR %s grants expected %b actual %b", name, exp, act);
        abort_run();
    end
endtask

task automatic check_resp_valid(string name, master_vec_t exp, master_vec_t act);
    if (act !== exp)
    begin
        $display("ERR %s response valids expected %b actual %b", name, exp, act);
        abort_run();
    end
endtask

`endif

// ==== test/tb_tcdm_request_block.sv ====
module tb_tcdm_request_block;

    import tcdm_req_pkg::*;

    localparam int          CLK_PERIOD   = 40;
    localparam int          DRIVE_DELAY  = 2;
    localparam int          RESET_CYCLES = 16;
    localparam int unsigned N_CH0        = 4;
    localparam int unsigned N_CH1        = 2;
    localparam int          N_ALL        = N_CH0 + N_CH1;

    // Cycle budget of each test
    localparam int ROT_CYCLES  = 12;
    localparam int ALT_CYCLES  = 24;
    localparam int RAND_CYCLES = 400;
    localparam int TS_CYCLES   = 8;
    localparam int RESP_CYCLES = 40;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + ROT_CYCLES + ALT_CYCLES + RAND_CYCLES
                                     + TS_CYCLES + RESP_CYCLES + 200;

    typedef logic [N_ALL-1:0] master_vec_t;

    logic                     clk;
    logic                     rst_n;
    master_vec_t              req;
    tcdm_req_t [N_ALL-1:0]    pay;
    master_vec_t              gnt;
    logic                     mem_req;
    mem_req_t                 mem_pay;
    logic                     mem_gnt;
    logic                     r_valid;
    logic [ID_WIDTH-1:0]      r_id;
    master_vec_t              rvalid;

    // Outputs captured at the falling edge
    master_vec_t              gnt_seen;
    logic                     mem_req_seen;
    mem_req_t                 mem_pay_seen;
    string                    test_name;

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    `include "tb_ref_model.svh"

    tcdm_request_block #(
        .N_CH0 ( N_CH0 ),
        .N_CH1 ( N_CH1 )
    ) uut (
        .clk_i         ( clk                 ),
        .rst_n_i       ( rst_n               ),
        .ch0_req_i     ( req[N_CH0-1:0]      ),
        .ch0_payload_i ( pay[N_CH0-1:0]      ),
        .ch0_gnt_o     ( gnt[N_CH0-1:0]      ),
        .ch1_req_i     ( req[N_ALL-1:N_CH0]  ),
        .ch1_payload_i ( pay[N_ALL-1:N_CH0]  ),
        .ch1_gnt_o     ( gnt[N_ALL-1:N_CH0]  ),
        .mem_req_o     ( mem_req             ),
        .mem_payload_o ( mem_pay             ),
        .mem_gnt_i     ( mem_gnt             ),
        .r_valid_i     ( r_valid             ),
        .r_id_i        ( r_id                ),
        .ch0_r_valid_o ( rvalid[N_CH0-1:0]   ),
        .ch1_r_valid_o ( rvalid[N_ALL-1:N_CH0] )
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all tests completed");
        abort_run();
    end

    //////////////////////////////////////////////////////////////////////
    // Comparison against the reference model, once per cycle
    //////////////////////////////////////////////////////////////////////

    initial
    begin : compare
        ref_state_t st;
        ref_state_t nxt;
        ref_out_t   exp;

        st = '0;
        forever
        begin
            @(negedge clk);
            if (!rst_n)
            begin
                st = '0;
            end
            else
            begin
                ref_step(st, req, pay, mem_gnt, exp, nxt);
                check_mem_port(test_name, exp.mem_req, exp.mem, mem_req, mem_pay);
                check_grants(test_name, exp.gnt, gnt);
                check_resp_valid(test_name, expected_rvalid(r_valid, r_id), rvalid);
                st = nxt;
            end
        end
    end

    task automatic next_cycle();
        @(negedge clk);
        gnt_seen     = gnt;
        mem_req_seen = mem_req;
        mem_pay_seen = mem_pay;
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    function automatic tcdm_req_t random_payload(int idx, bit ts_en);
        tcdm_req_t p;
        p.addr.raw = {ts_en && ($urandom % 4 == 0), $urandom};
        p.wen      = 1'($urandom);
        p.wdata    = $urandom;
        p.be       = 4'($urandom);
        p.id       = '0;
        p.id[idx]  = 1'b1;
        return p;
    endfunction

    // Granted masters drop, idle masters in the mask may raise a new request
    task automatic drive_masters(master_vec_t mask, int pct, bit ts_en, master_vec_t granted);
        for (int i = 0; i < N_ALL; i++)
        begin
            if (req[i] && granted[i])
            begin
                req[i] = 1'b0;
            end
            if (!req[i] && mask[i] && int'($urandom % 100) < pct)
            begin
                req[i] = 1'b1;
                pay[i] = random_payload(i, ts_en);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial
    begin : stimulus
        logic      last_ch1;
        tcdm_req_t ts_load;
        mem_req_t  exp_mem;

        rst_n     = 1'b0;
        req       = '0;
        pay       = '0;
        mem_gnt   = 1'b0;
        r_valid   = 1'b0;
        r_id      = '0;
        test_name = "reset";
        void'($urandom(32'h6949));
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;

        // Channel 0 alone, grants must rotate from index 0
        test_name = "rotation";
        mem_gnt   = 1'b1;
        drive_masters(master_vec_t'((1 << N_CH0) - 1), 100, 1'b0, '0);
        for (int k = 0; k < ROT_CYCLES; k++)
        begin
            next_cycle();
            check_grants(test_name, master_vec_t'(1) << (k % N_CH0), gnt_seen);
            drive_masters(master_vec_t'((1 << N_CH0) - 1), 100, 1'b0, gnt_seen);
        end

        test_name = "channel_alternation";
        drive_masters('1, 100, 1'b0, '0);
        last_ch1 = 1'b1;
        for (int k = 0; k < ALT_CYCLES; k++)
        begin
            next_cycle();
            if (gnt_seen == '0)
            begin
                $display("No master was granted while every master requested");
                abort_run();
            end
            if (k > 0 && (|gnt_seen[N_ALL-1:N_CH0]) == last_ch1)
            begin
                $display("Channel grants did not alternate under contention");
                abort_run();
            end
            last_ch1 = |gnt_seen[N_ALL-1:N_CH0];
            drive_masters('1, 100, 1'b0, gnt_seen);
        end

        test_name = "random_backpressure";
        for (int k = 0; k < RAND_CYCLES; k++)
        begin
            next_cycle();
            if (!mem_gnt && gnt_seen != '0)
            begin
                $display("A master was granted while memory held its grant low");
                abort_run();
            end
            drive_masters('1, 50, 1'b1, gnt_seen);
            mem_gnt = ($urandom % 10) < 6;
        end
        // Let every open request finish before the next test
        mem_gnt = 1'b1;
        while (req != '0)
        begin
            next_cycle();
            drive_masters('1, 0, 1'b0, gnt_seen);
        end

        test_name             = "test_and_set";
        ts_load               = '0;
        ts_load.addr.dec.ts   = 1'b1;
        ts_load.addr.dec.addr = 32'h0000_1a40;
        ts_load.wen           = 1'b1;
        ts_load.be            = '1;
        ts_load.id            = 8'h02;
        pay[1]                = ts_load;
        req[1]                = 1'b1;
        do
        begin
            next_cycle();
        end
        while (!gnt_seen[1]);
        exp_mem = '{addr: 32'h0000_1a40, wen: 1'b1, wdata: '0, be: '1, id: 8'h02, ts_set: 1'b0};
        check_mem_port("ts_load", 1'b1, exp_mem, mem_req_seen, mem_pay_seen);
        // A DMA request arrives while the set store is on the port
        req[1]     = 1'b0;
        pay[N_CH0] = random_payload(N_CH0, 1'b0);
        req[N_CH0] = 1'b1;
        next_cycle();
        exp_mem = '{addr: 32'h0000_1a40, wen: 1'b0, wdata: TS_SET_VALUE, be: '1,
                    id: 8'h02, ts_set: 1'b1};
        check_mem_port("ts_set_store", 1'b1, exp_mem, mem_req_seen, mem_pay_seen);
        check_grants("ts_set_stall", '0, gnt_seen);
        next_cycle();
        check_grants("after_set_store", master_vec_t'(1) << N_CH0, gnt_seen);
        req[N_CH0] = 1'b0;

        test_name = "response_valid";
        for (int k = 0; k < RESP_CYCLES / 2; k++)
        begin
            r_id                        = '0;
            r_id[$urandom % ID_WIDTH]   = 1'b1;
            r_valid                     = 1'b1;
            next_cycle();
            r_valid = 1'b0;
            next_cycle();
        end

        next_cycle();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== tcdm_request_block.f ====
+incdir+test
hdl/tcdm_req_pkg.sv
hdl/rr_arbiter.sv
hdl/channel_mux.sv
hdl/test_and_set.sv
hdl/tcdm_request_block.sv
test/tb_tcdm_request_block.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --timing --assert
TB_TOP    := tb_tcdm_request_block
FILELIST  := tcdm_request_block.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

# Lint the whole project, testbench included
lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

# Build and run, the exit status carries pass or fail
sim:
	$(VERILATOR) --binary -j 0 $(FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)
